/* files.f */
verilog/rv_pkg.sv
verilog/rv_ifu.sv
verilog/rv_idu.sv
verilog/rv_gpr.sv
verilog/rv_exu.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
verif/tb_clock.sv
verif/tb_core.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_core -o sim_core

output=$(./obj_dir/sim_core)
echo "$output"

echo "$output" | grep -q "Simulation PASSED"

/* verif/core_vectors.txt */
# P byte_address word0 word1 word2 word3 (consecutive program words)
# E pc wb_en rd rd_data (one line per retirement, rd and rd_data ignored when wb_en is 0)
P 00 00500093 FFD00113 123451B7 00001217
P 10 002082B3 40208333 401153B3 00112433
P 20 001134B3 01C15513 0030C5B3 00108033
P 30 00100633 00108463 06300693 00109463
P 40 00300693 FFF68693 FED04EE3 00C0076F
P 50 00100793 00100793 010707E7 00100793
P 60 08000813 00382023 00182223 00281323
P 70 002800A3 00082883 00681903 00685983
P 80 00180A03 00184A83 00481B03 0000006F
E 00 1 01 00000005
E 04 1 02 FFFFFFFD
E 08 1 03 12345000
E 0C 1 04 0000100C
E 10 1 05 00000002
E 14 1 06 00000008
E 18 1 07 FFFFFFFF
E 1C 1 08 00000001
E 20 1 09 00000000
E 24 1 0A 0000000F
E 28 1 0B 12345005
E 2C 1 00 0000000A
E 30 1 0C 00000005
E 34 0 00 00000000
E 3C 0 00 00000000
E 40 1 0D 00000003
E 44 1 0D 00000002
E 48 0 00 00000000
E 44 1 0D 00000001
E 48 0 00 00000000
E 44 1 0D 00000000
E 48 0 00 00000000
E 4C 1 0E 00000050
E 58 1 0F 0000005C
E 60 1 10 00000080
E 64 0 00 00000000
E 68 0 00 00000000
E 6C 0 00 00000000
E 70 0 00 00000000
E 74 1 11 1234FD00
E 78 1 12 FFFFFFFD
E 7C 1 13 0000FFFD
E 80 1 14 FFFFFFFD
E 84 1 15 000000FD
E 88 1 16 00000005

/* verif/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    localparam int PROG_WORDS = 64;     // 256 bytes of program space
    localparam int MAX_EXP    = 128;

    logic             clk;
    logic             reset;
    logic [31:0]      imem_data;
    logic [31:0]      imem_addr;
    logic [31:0]      pc;
    logic [31:0]      inst;
    logic             retire;
    rv_pkg::retire_t  retire_info;

    logic [31:0] prog    [0:PROG_WORDS-1];
    logic [31:0] exp_pc  [0:MAX_EXP-1];
    logic        exp_wb  [0:MAX_EXP-1];  // rd and data only checked when set
    logic [4:0]  exp_rd  [0:MAX_EXP-1];
    logic [31:0] exp_val [0:MAX_EXP-1];
    int          n_exp;                  // E lines read
    int          n_ret;                  // retirements matched so far
    logic        loaded;

    tb_clock #(.PERIOD(100)) u_clock (.clk(clk));

    rv_core UUT (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
        .pc(pc), .inst(inst), .retire(retire), .retire_info(retire_info)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    // P lines carry a byte address and four program words
    // E lines carry pc, wb_en, rd and rd_data of one retirement
    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] addr;
        logic [31:0] w [0:3];
        logic [31:0] f_pc;
        logic [31:0] f_wb;
        logic [31:0] f_rd;
        logic [31:0] f_val;
        for (int i = 0; i < PROG_WORDS; i++)
            prog[i] = {i[24:0], 7'h7f};  // unknown opcode that retires as a no-op
        n_exp = 0;
        fd = $fopen("verif/core_vectors.txt", "r");
        if (fd == 0)
            fail_run("could not open the vectors file verif/core_vectors.txt");
        while (!$feof(fd))
        begin
            line = "";
            code = $fgets(line, fd);
            if (line.len() == 0)
                continue;
            if (line.getc(0) == "P")
            begin
                code = $sscanf(line, "P %h %h %h %h %h", addr, w[0], w[1], w[2], w[3]);
                if (code != 5)
                    fail_run({"malformed program line in the vectors file: ", line});
                for (int k = 0; k < 4; k++)
                    prog[addr[7:2] + k] = w[k];     // word index within program space
            end
            else if (line.getc(0) == "E")
            begin
                code = $sscanf(line, "E %h %h %h %h", f_pc, f_wb, f_rd, f_val);
                if (code != 4 || n_exp >= MAX_EXP)
                    fail_run({"malformed or surplus trace line in the vectors file: ", line});
                exp_pc[n_exp]  = f_pc;
                exp_wb[n_exp]  = f_wb[0];
                exp_rd[n_exp]  = f_rd[4:0];
                exp_val[n_exp] = f_val;
                n_exp++;
            end
        end
        $fclose(fd);
    endtask

    task automatic compare_retire();
        logic [31:0] exp_inst;
        if (n_ret < n_exp)
        begin
            exp_inst = prog[exp_pc[n_ret][7:2]];    // program word at the expected pc
            check_value("retire_info.pc", retire_info.pc, exp_pc[n_ret]);
            check_value("retire_info.inst", retire_info.inst, exp_inst);
            check_value("pc", pc, exp_pc[n_ret]);
            check_value("inst", inst, exp_inst);
            check_value("imem_addr", imem_addr, exp_pc[n_ret]);
            check_value("retire_info.wb_en", {31'd0, retire_info.wb_en},
                        {31'd0, exp_wb[n_ret]});
            if (exp_wb[n_ret])
            begin
                check_value("retire_info.rd", {27'd0, retire_info.rd}, {27'd0, exp_rd[n_ret]});
                check_value("retire_info.rd_data", retire_info.rd_data, exp_val[n_ret]);
            end
            n_ret++;
            if (n_ret == n_exp)
            begin
                $display("Simulation PASSED");
                $finish;
            end
        end
    endtask

    initial
    begin
        reset     = 1'b1;
        imem_data = 32'd0;
        n_ret     = 0;
        loaded    = 1'b0;
        load_vectors();
        loaded    = 1'b1;
        repeat (5)
        begin
            @(negedge clk);
            check_value("retire", {31'd0, retire}, 32'd0);  // quiet during reset
            check_value("pc", pc, 32'h0);
        end
        reset = 1'b0;                   // released on a falling edge
        #1;
        check_value("retire", {31'd0, retire}, 32'd0);  // still in first fetch
        check_value("pc", pc, 32'h0);
    end

    // instruction port served and trace sampled mid-cycle
    always @(negedge clk)
    begin
        imem_data = prog[imem_addr[7:2]];
        if (!reset && retire)
            compare_retire();
    end

    // worst case 3 cycles per retirement plus reset margin
    initial
    begin
        wait (loaded);
        repeat (n_exp * 3 + 20) @(posedge clk);
        $display("timeout: the core stopped retiring after %0d of %0d instructions",
                 n_ret, n_exp);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 100          // ns
) (
    output logic clk
);
    initial
        clk = 1'b0;                     // first rising edge at half a period

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter logic [31:0] RESET_PC   = 32'h0,
    parameter int          DMEM_WORDS = 256
) (
    input  wire              clk,
    input  wire              reset,
    output logic [31:0]      imem_addr,
    input  wire  [31:0]      imem_data,
    output logic [31:0]      pc,
    output logic [31:0]      inst,
    output logic             retire,
    output rv_pkg::retire_t  retire_info
);
    rv_pkg::ctrl_t ctrl;
    logic [31:0]   imm;
    logic [31:0]   rs1_data, rs2_data;
    logic [31:0]   alu_out;
    logic          branch_taken;
    logic [31:0]   mem_rd_data;     // load result from lsu
    logic          mem_start, mem_done;
    logic          commit;
    logic          jump_en;
    logic [31:0]   jump_pc;
    logic [31:0]   pc_plus4;
    logic [31:0]   wr_data;         // writeback value

    assign pc_plus4 = pc + 32'd4;
    assign jump_en  = ctrl.jump | branch_taken;
    assign jump_pc  = {alu_out[31:1], 1'b0};    // jalr clears bit 0

    always_comb
    begin
        case (ctrl.wb_sel)
            rv_pkg::WB_PC4: wr_data = pc_plus4;     // link address
            rv_pkg::WB_MEM: wr_data = mem_rd_data;
            default:        wr_data = alu_out;
        endcase
    end

    assign retire      = commit;
    assign retire_info = '{pc: pc, inst: inst, rd: inst[11:7], rd_data: wr_data,
                           wb_en: ctrl.wb_en};

    rv_ifu #(.RESET_PC(RESET_PC)) u_ifu (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
        .is_mem(ctrl.mem_rd | ctrl.mem_wr), .jump(jump_en), .jump_pc(jump_pc),
        .mem_done(mem_done), .pc(pc), .inst(inst), .mem_start(mem_start), .commit(commit)
    );

    rv_idu u_idu (.inst(inst), .ctrl(ctrl), .imm(imm));

    rv_gpr u_gpr (
        .clk(clk), .rs1_addr(inst[19:15]), .rs2_addr(inst[24:20]), .rd_addr(inst[11:7]),
        .wr_en(commit & ctrl.wb_en), .wr_data(wr_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_exu u_exu (
        .ctrl(ctrl), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .alu_out(alu_out), .branch_taken(branch_taken)
    );

    rv_lsu #(.DMEM_WORDS(DMEM_WORDS)) u_lsu (
        .clk(clk), .reset(reset), .start(mem_start), .ctrl(ctrl), .addr(alu_out),
        .wr_data(rs2_data), .rd_data(mem_rd_data), .done(mem_done)
    );

endmodule

`default_nettype wire

/* verilog/rv_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_lsu #(
    parameter int DMEM_WORDS = 256
) (
    input  wire           clk,
    input  wire           reset,
    input  wire           start,        // one-cycle pulse in exec
    input  rv_pkg::ctrl_t ctrl,
    input  wire  [31:0]   addr,
    input  wire  [31:0]   wr_data,
    output logic [31:0]   rd_data,
    output logic          done
);
    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [31:0]      ram [0:DMEM_WORDS-1];
    logic [IDX_W-1:0] idx;
    logic [1:0]       lane;             // byte offset in word
    logic [3:0]       be;
    logic [31:0]      wdata;
    logic [31:0]      rword;            // read word shifted down to lane 0
    logic [31:0]      ld_ext;

    assign idx   = addr[IDX_W+1:2];
    assign lane  = addr[1:0];
    assign wdata = wr_data << {lane, 3'b000};   // move store data to its lane
    assign rword = ram[idx] >> {lane, 3'b000};

    always_comb
    begin
        case (ctrl.mem_size)
            rv_pkg::MEM_BYTE:
            begin
                be     = 4'b0001 << lane;
                ld_ext = ctrl.mem_unsigned ? {24'd0, rword[7:0]} : {{24{rword[7]}}, rword[7:0]};
            end
            rv_pkg::MEM_HALF:
            begin
                be     = 4'b0011 << lane;   // lane 0 or 2 assumed
                ld_ext = ctrl.mem_unsigned ? {16'd0, rword[15:0]}
                                           : {{16{rword[15]}}, rword[15:0]};
            end
            default:
            begin
                be     = 4'b1111;
                ld_ext = rword;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (start && ctrl.mem_wr)
        begin
            for (int b = 0; b < 4; b++)
                if (be[b])
                    ram[idx][8*b +: 8] <= wdata[8*b +: 8];  // byte-enabled write
        end
        if (start && ctrl.mem_rd)
            rd_data <= ld_ext;  // valid together with done
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            done <= 1'b0;
        else
            done <= start;      // fixed one-cycle latency
    end

    a_start_rw: assert property (@(posedge clk) disable iff (reset)
        start |-> (ctrl.mem_rd != ctrl.mem_wr));

endmodule

`default_nettype wire

/* verilog/rv_exu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exu (
    input  rv_pkg::ctrl_t ctrl,
    input  wire  [31:0]   pc,
    input  wire  [31:0]   rs1_data,
    input  wire  [31:0]   rs2_data,
    input  wire  [31:0]   imm,
    output logic [31:0]   alu_out,
    output logic          branch_taken
);
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;

    assign op_a  = ctrl.alu_a_pc ? pc : rs1_data;
    assign op_b  = ctrl.alu_b_imm ? imm : rs2_data;
    assign shamt = op_b[4:0];           // rv32 shifts use low 5 bits

    always_comb
    begin
        case (ctrl.alu_op)
            rv_pkg::ALU_ADD:    alu_out = op_a + op_b;
            rv_pkg::ALU_SUB:    alu_out = op_a - op_b;
            rv_pkg::ALU_SLL:    alu_out = op_a << shamt;
            rv_pkg::ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU:   alu_out = {31'd0, op_a < op_b};
            rv_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            rv_pkg::ALU_SRL:    alu_out = op_a >> shamt;
            rv_pkg::ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:     alu_out = op_a | op_b;
            rv_pkg::ALU_AND:    alu_out = op_a & op_b;
            rv_pkg::ALU_PASS_B: alu_out = op_b;
            default:            alu_out = 32'd0;
        endcase
    end

    // branch comparator works on the register values, not the alu operands
    always_comb
    begin
        case (ctrl.br_type)
            rv_pkg::BR_EQ:  branch_taken = (rs1_data == rs2_data);
            rv_pkg::BR_NE:  branch_taken = (rs1_data != rs2_data);
            rv_pkg::BR_LT:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            rv_pkg::BR_GE:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            rv_pkg::BR_LTU: branch_taken = (rs1_data < rs2_data);
            rv_pkg::BR_GEU: branch_taken = (rs1_data >= rs2_data);
            default:        branch_taken = 1'b0;    // not a branch
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rv_gpr.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_gpr (
    input  wire         clk,
    input  wire  [4:0]  rs1_addr,
    input  wire  [4:0]  rs2_addr,
    input  wire  [4:0]  rd_addr,
    input  wire         wr_en,          // commit and wb_en
    input  wire  [31:0] wr_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);
    logic [31:0] regs [0:31];           // entry 0 never written

    // async reads, x0 forced to zero
    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

    always_ff @(posedge clk)
    begin
        if (wr_en && rd_addr != 5'd0)   // drop writes to x0
            regs[rd_addr] <= wr_data;
    end

    a_x0_zero: assert property (@(posedge clk) (rs1_addr == 5'd0) |-> (rs1_data == 32'd0));

endmodule

`default_nettype wire

/* verilog/rv_idu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_idu (
    input  wire  [31:0]        inst,
    output rv_pkg::ctrl_t      ctrl,
    output logic [31:0]        imm
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7b;                    // funct7[5], sub / sra select

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign f7b    = inst[30];

    // funct3 to alu function, sub only exists for reg-reg
    function automatic rv_pkg::alu_op_t alu_func(input logic [2:0] f3, input logic f7,
                                                 input logic is_reg);
        rv_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = (is_reg && f7) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = f7 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;   // srai shares bit 30
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb
    begin
        ctrl = '0;                      // unknown opcode retires as nop
        imm  = {{20{inst[31]}}, inst[31:20]};   // i-type by default
        case (opcode)
            rv_pkg::OP_LUI:
            begin
                imm            = {inst[31:12], 12'b0};
                ctrl.alu_b_imm = 1'b1;
                ctrl.alu_op    = rv_pkg::ALU_PASS_B;
                ctrl.wb_en     = 1'b1;
            end
            rv_pkg::OP_AUIPC:
            begin
                imm            = {inst[31:12], 12'b0};
                ctrl.alu_a_pc  = 1'b1;
                ctrl.alu_b_imm = 1'b1;
                ctrl.wb_en     = 1'b1;
            end
            rv_pkg::OP_JAL:
            begin
                imm            = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                  inst[30:21], 1'b0};
                ctrl.alu_a_pc  = 1'b1;  // target = pc + imm
                ctrl.alu_b_imm = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.wb_en     = 1'b1;
                ctrl.wb_sel    = rv_pkg::WB_PC4;    // link
            end
            rv_pkg::OP_JALR:
            begin
                ctrl.alu_b_imm = 1'b1;  // target = rs1 + imm
                ctrl.jump      = 1'b1;
                ctrl.wb_en     = 1'b1;
                ctrl.wb_sel    = rv_pkg::WB_PC4;
            end
            rv_pkg::OP_BRANCH:
            begin
                imm            = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                  inst[11:8], 1'b0};
                ctrl.alu_a_pc  = 1'b1;
                ctrl.alu_b_imm = 1'b1;
                case (funct3)
                    3'b000:  ctrl.br_type = rv_pkg::BR_EQ;
                    3'b001:  ctrl.br_type = rv_pkg::BR_NE;
                    3'b100:  ctrl.br_type = rv_pkg::BR_LT;
                    3'b101:  ctrl.br_type = rv_pkg::BR_GE;
                    3'b110:  ctrl.br_type = rv_pkg::BR_LTU;
                    3'b111:  ctrl.br_type = rv_pkg::BR_GEU;
                    default: ctrl.br_type = rv_pkg::BR_NONE;  // reserved, falls through
                endcase
            end
            rv_pkg::OP_LOAD:
            begin
                ctrl.alu_b_imm    = 1'b1;   // addr = rs1 + imm
                ctrl.wb_en        = 1'b1;
                ctrl.wb_sel       = rv_pkg::WB_MEM;
                ctrl.mem_rd       = 1'b1;
                ctrl.mem_size     = rv_pkg::mem_size_t'(funct3[1:0]);
                ctrl.mem_unsigned = funct3[2];
            end
            rv_pkg::OP_STORE:
            begin
                imm            = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                ctrl.alu_b_imm = 1'b1;
                ctrl.mem_wr    = 1'b1;
                ctrl.mem_size  = rv_pkg::mem_size_t'(funct3[1:0]);
            end
            rv_pkg::OP_IMM:
            begin
                ctrl.alu_b_imm = 1'b1;
                ctrl.alu_op    = alu_func(funct3, f7b, 1'b0);
                ctrl.wb_en     = 1'b1;
            end
            rv_pkg::OP_OP:
            begin
                ctrl.alu_op = alu_func(funct3, f7b, 1'b1);
                ctrl.wb_en  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rv_ifu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_ifu #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  wire         clk,
    input  wire         reset,
    output logic [31:0] imem_addr,
    input  wire  [31:0] imem_data,
    input  wire         is_mem,         // current inst is a load or store
    input  wire         jump,
    input  wire  [31:0] jump_pc,
    input  wire         mem_done,
    output logic [31:0] pc,
    output logic [31:0] inst,
    output logic        mem_start,
    output logic        commit
);
    localparam logic [1:0] S_FETCH = 2'd0;
    localparam logic [1:0] S_EXEC  = 2'd1;
    localparam logic [1:0] S_MEM   = 2'd2;

    logic [1:0] state;
    logic       fetch_done;             // inst latched last edge, so we are in exec

    assign imem_addr = {pc[31:2], 2'b00};   // word aligned
    assign mem_start = fetch_done & is_mem; // exec cycle of a load/store
    assign commit    = (state == S_EXEC && !is_mem) || (state == S_MEM && mem_done);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= S_FETCH;
            pc         <= RESET_PC;
            fetch_done <= 1'b0;
        end
        else
        begin
            fetch_done <= (state == S_FETCH);
            case (state)
                S_FETCH: state <= S_EXEC;
                S_EXEC:  state <= is_mem ? S_MEM : S_FETCH;
                S_MEM:   state <= mem_done ? S_FETCH : S_MEM;   // wait for lsu
                default: state <= S_FETCH;
            endcase
            if (commit)
                pc <= jump ? jump_pc : pc + 32'd4;  // next inst
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_FETCH)
            inst <= imem_data;  // latched at the edge ending fetch
    end

    a_state_legal: assert property (@(posedge clk) disable iff (reset) state != 2'd3);

endmodule

`default_nettype wire

/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // lui just forwards the immediate
    } alu_op_t;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU} br_type_t;

    typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_MEM} wb_sel_t;     // writeback source

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_t;  // matches funct3[1:0]

    typedef struct packed {
        logic      alu_a_pc;        // operand a from pc
        logic      alu_b_imm;       // operand b from imm
        alu_op_t   alu_op;
        br_type_t  br_type;
        logic      jump;            // jal / jalr
        logic      wb_en;
        wb_sel_t   wb_sel;
        logic      mem_rd;
        logic      mem_wr;
        mem_size_t mem_size;
        logic      mem_unsigned;    // lbu / lhu
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [4:0]  rd;
        logic [31:0] rd_data;
        logic        wb_en;
    } retire_t;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;

endpackage

`default_nettype wire
